/* design/cpuPkg.sv */
`default_nettype none

package cpuPkg;

    typedef logic signed [31:0] word_t;   // Signed in arithmetic
    typedef logic [31:0] instr_t;
    typedef logic [4:0] regIdx_t;
    typedef logic [15:0] imm_t;

    // Primary opcode in instr[31:26]
    typedef enum logic [5:0] {
        OpNop  = 6'h00,
        OpAdd  = 6'h01,
        OpSub  = 6'h02,
        OpAnd  = 6'h03,
        OpOr   = 6'h04,
        OpXor  = 6'h05,
        OpSlt  = 6'h06,
        OpAddi = 6'h08,
        OpLui  = 6'h0F
    } opcode_e;

    typedef struct packed {
        opcode_e op;
        regIdx_t rs;
        regIdx_t rt;
        regIdx_t rd;        // Final destination, rt already chosen for immediate forms
        word_t   imm;       // Sign-extended
        logic    useImm;
        logic    writes;
        logic    illegal;
    } decoded_t;

    // One write into the register bank
    typedef struct packed {
        logic    en;
        regIdx_t dest;
        word_t   data;
    } wrPort_t;

endpackage

`default_nettype wire

/* design/regBank.sv */
`timescale 1ns/1ps
`default_nettype none

module regBank import cpuPkg::*; #(
    parameter int unsigned NumRegs  = 17,
    parameter word_t       RetReset = 32'sd1023
) (
    input  wire     clk,
    input  wire     rst,
    input  regIdx_t rs,
    input  regIdx_t rt,
    input  wrPort_t wr,
    output word_t   rdData1,
    output word_t   rdData2
);

    // Highest valid index, which is also the return register
    localparam regIdx_t LastIdx = regIdx_t'(NumRegs - 1);

    // R0 has no storage since it always reads as zero
    word_t regs [1:NumRegs-1];

    logic wrHit;

    function automatic logic inRange(input regIdx_t idx);
        return (idx != '0) && (idx <= LastIdx);
    endfunction

    // Two combinational read ports
    always_comb begin
        rdData1 = '0;
        rdData2 = '0;
        if (inRange(rs)) begin
            rdData1 = regs[rs];
        end
        if (inRange(rt)) begin
            rdData2 = regs[rt];
        end
    end

    assign wrHit = wr.en && inRange(wr.dest);   // Index 0 and out of range fall away here

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
            regs[LastIdx] <= RetReset;  // Return register
        end else if (wrHit) begin
            regs[wr.dest] <= wr.data;
        end
    end

endmodule

`default_nettype wire

/* design/instrDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instrDecoder import cpuPkg::*; (
    input  instr_t   instr,
    output decoded_t decoded
);

    logic [5:0] opField;
    regIdx_t    rsField;
    regIdx_t    rtField;
    regIdx_t    rdField;
    imm_t       immField;
    word_t      immExt;

    // Field slicing
    assign opField  = instr[31:26];
    assign rsField  = instr[25:21];
    assign rtField  = instr[20:16];
    assign rdField  = instr[15:11];   // Overlaps the top of the immediate
    assign immField = instr[15:0];

    assign immExt = {{16{immField[15]}}, immField};

    always_comb begin
        decoded         = '0;
        decoded.op      = OpNop;
        decoded.rs      = rsField;
        decoded.rt      = rtField;
        decoded.rd      = rdField;
        decoded.imm     = immExt;
        decoded.useImm  = 1'b0;
        decoded.writes  = 1'b0;
        decoded.illegal = 1'b0;

        case (opField)
            OpNop: begin
                decoded.op = OpNop;
            end
            OpAdd, OpSub, OpAnd, OpOr, OpXor, OpSlt: begin
                decoded.op     = opcode_e'(opField);
                decoded.writes = 1'b1;
            end
            OpAddi: begin
                decoded.op     = OpAddi;
                decoded.rd     = rtField;   // Immediate forms target rt
                decoded.useImm = 1'b1;
                decoded.writes = 1'b1;
            end
            OpLui: begin
                decoded.op     = OpLui;
                decoded.rd     = rtField;
                decoded.useImm = 1'b1;
                decoded.writes = 1'b1;
            end
            default: begin
                // Unknown code runs as a NOP that never writes
                decoded.op      = OpNop;
                decoded.illegal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/aluUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module aluUnit import cpuPkg::*; (
    input  wire      clk,
    input  wire      rst,
    input  wire      instrValid,
    input  decoded_t decoded,
    input  word_t    opA,
    input  word_t    opB,
    output wrPort_t  wr,
    output logic     resultValid,
    output logic     errorFlag,
    output word_t    resultData
);

    word_t operandB;
    word_t aluResult;
    logic  doWrite;

    assign operandB = decoded.useImm ? decoded.imm : opB;

    always_comb begin
        case (decoded.op)
            OpAdd, OpAddi: aluResult = opA + operandB;   // Wraps at 32 bits
            OpSub:         aluResult = opA - operandB;
            OpAnd:         aluResult = opA & operandB;
            OpOr:          aluResult = opA | operandB;
            OpXor:         aluResult = opA ^ operandB;
            OpSlt: begin
                // Both operands are signed words
                aluResult = (opA < operandB) ? 32'sd1 : 32'sd0;
            end
            OpLui:         aluResult = {decoded.imm[15:0], 16'h0000};
            default:       aluResult = '0;
        endcase
    end

    // Write-back lands on the same edge that samples the instruction
    assign doWrite = instrValid && decoded.writes && !decoded.illegal;

    always_comb begin
        wr      = '0;
        wr.en   = doWrite;
        wr.dest = decoded.rd;
        wr.data = aluResult;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resultValid <= 1'b0;
            errorFlag   <= 1'b0;
            resultData  <= '0;
        end else begin
            resultValid <= instrValid && !decoded.illegal;
            errorFlag   <= instrValid && decoded.illegal;
            if (instrValid) begin
                resultData <= aluResult;   // Illegal codes decode as NOP and give zero
            end
        end
    end

endmodule

`default_nettype wire

/* design/execCore.sv */
`timescale 1ns/1ps
`default_nettype none

module execCore import cpuPkg::*; #(
    parameter int unsigned NumRegs  = 17,
    parameter word_t       RetReset = 32'sd1023
) (
    input  wire    clk,
    input  wire    rst,
    input  wire    instrValid,
    input  instr_t instr,
    output logic   resultValid,
    output logic   errorFlag,
    output word_t  resultData
);

    decoded_t decoded;
    word_t    rdData1;
    word_t    rdData2;
    wrPort_t  wrPort;

    // Decoder and bank work side by side on the same instruction
    instrDecoder instrDecoder_inst (
        .instr   (instr),
        .decoded (decoded)
    );

    regBank #(
        .NumRegs  (NumRegs),
        .RetReset (RetReset)
    ) regBank_inst (
        .clk     (clk),
        .rst     (rst),
        .rs      (decoded.rs),
        .rt      (decoded.rt),
        .wr      (wrPort),
        .rdData1 (rdData1),
        .rdData2 (rdData2)
    );

    aluUnit aluUnit_inst (
        .clk         (clk),
        .rst         (rst),
        .instrValid  (instrValid),
        .decoded     (decoded),
        .opA         (rdData1),
        .opB         (rdData2),
        .wr          (wrPort),          // Back into the bank
        .resultValid (resultValid),
        .errorFlag   (errorFlag),
        .resultData  (resultData)
    );

endmodule

`default_nettype wire

/* tests/clockGen.sv */
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
    parameter int PeriodNs = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PeriodNs / 2) clk = ~clk;   // Half period per edge
        end
    end

endmodule

`default_nettype wire

/* tests/execCore_props.sv */
`timescale 1ns/1ps
`default_nettype none

module execCore_props (
    input wire clk,
    input wire rst,
    input wire instrValid,
    input wire resultValid,
    input wire errorFlag
);

    // Valid and error pulses never overlap
    validErrorExclusive: assert property (
        @(posedge clk) disable iff (rst) !(resultValid && errorFlag)
    ) else $error("resultValid and errorFlag high in the same cycle");

    // Every accepted instruction answers one cycle later
    pulseAfterInstr: assert property (
        @(posedge clk) disable iff (rst) instrValid |=> (resultValid || errorFlag)
    ) else $error("No resultValid or errorFlag one cycle after instrValid");

    noPulseWhenIdle: assert property (
        @(posedge clk) disable iff (rst) !instrValid |=> !(resultValid || errorFlag)
    ) else $error("Output pulse without an instruction in the previous cycle");

    // Reset clears both flags on the next edge
    quietInReset: assert property (
        @(posedge clk) rst |=> (!resultValid && !errorFlag)
    ) else $error("resultValid or errorFlag high during reset");

endmodule

`default_nettype wire

/* tests/execCoreTb.sv */
`timescale 1ns/1ps
`default_nettype none

module execCoreTb import cpuPkg::*; ();

    localparam int MaxRows     = 64;
    localparam int Cols        = 5;     // Words per golden row
    localparam int ResetCycles = 8;
    localparam int SettleLimit = 20;
    localparam int DriveDelay  = 1;

    logic   clk;
    logic   rst;
    logic   instrValid;
    instr_t instr;
    logic   resultValid;
    logic   errorFlag;
    word_t  resultData;

    // Mode, instruction, valid, error, result for each row
    logic [31:0] golden [0:MaxRows*Cols-1];

    int passCount;
    int failCount;

    clockGen #(
        .PeriodNs (8)
    ) clockGen_inst (
        .clk (clk)
    );

    execCore #(
        .NumRegs  (17),
        .RetReset (32'sd1023)
    ) execCore_inst (
        .clk         (clk),
        .rst         (rst),
        .instrValid  (instrValid),
        .instr       (instr),
        .resultValid (resultValid),
        .errorFlag   (errorFlag),
        .resultData  (resultData)
    );

    bind execCore execCore_props execCore_props_inst (
        .clk         (clk),
        .rst         (rst),
        .instrValid  (instrValid),
        .resultValid (resultValid),
        .errorFlag   (errorFlag)
    );

    // Rows before the end marker, -1 if there is none
    function automatic int countRows();
        for (int i = 0; i < MaxRows; i++) begin
            if (golden[i*Cols] == 32'hF) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic holdReset();
        rst = 1'b1;
        for (int c = 0; c < ResetCycles; c++) begin
            @(posedge clk);
        end
        #DriveDelay;
        rst = 1'b0;
    endtask

    task automatic waitSettled(output bit ok);
        ok = 1'b0;
        for (int c = 0; c < SettleLimit; c++) begin
            @(posedge clk);
            #DriveDelay;
            if (!rst && !resultValid && !errorFlag) begin
                ok = 1'b1;
                return;
            end
        end
    endtask

    task automatic driveRow(input int row);
        instrValid = golden[row*Cols][0];   // Mode 0 leaves the core idle
        instr      = golden[row*Cols+1];
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp,
                            inout bit ok);
        if (got !== exp) begin
            $display("[ERROR] %0t %s expected %0b got %0b", $time, name, exp, got);
            ok = 1'b0;
        end
    endtask

    task automatic checkWord(input string name, input word_t got, input word_t exp,
                             inout bit ok);
        if (got !== exp) begin
            $display("[ERROR] %0t %s expected %08h got %08h", $time, name, exp, got);
            ok = 1'b0;
        end
    endtask

    // Result register comes out of reset cleared
    task automatic checkResetState();
        bit ok;
        ok = 1'b1;
        checkWord("resultData", resultData, '0, ok);
        if (ok) begin
            passCount++;
        end else begin
            failCount++;
        end
        $display("reset state: %s", ok ? "passed" : "failed");
    endtask

    task automatic checkRow(input int row);
        logic  expValid;
        logic  expError;
        word_t expResult;
        bit    ok;
        expValid  = golden[row*Cols+2][0];
        expError  = golden[row*Cols+3][0];
        expResult = golden[row*Cols+4];
        ok        = 1'b1;
        checkBit("resultValid", resultValid, expValid, ok);
        checkBit("errorFlag", errorFlag, expError, ok);
        if (expValid) begin
            checkWord("resultData", resultData, expResult, ok);
        end
        if (ok) begin
            passCount++;
        end else begin
            failCount++;
        end
        $display("row %0d instr %08h: %s", row, golden[row*Cols+1], ok ? "passed" : "failed");
    endtask

    task automatic runRows(input int rows);
        // Check of row r and drive of row r+1 share one slot after the edge
        for (int r = 0; r < rows; r++) begin
            driveRow(r);
            @(posedge clk);
            #DriveDelay;
            checkRow(r);
        end
        instrValid = 1'b0;
        instr      = '0;
    endtask

    initial begin
        int rows;
        bit settled;
        rst        = 1'b1;
        instrValid = 1'b0;
        instr      = '0;
        passCount  = 0;
        failCount  = 0;
        $readmemh("tests/execCore_golden.txt", golden);
        rows = countRows();
        holdReset();
        waitSettled(settled);
        if (!settled) begin
            $display("Timed out waiting for reset release with quiet outputs");
            $display("Test FAILED");
        end else begin
            checkResetState();
            if (rows <= 0) begin
                $display("Golden file holds no rows or lacks its end marker");
                failCount++;
            end
            runRows(rows);
            @(posedge clk);
            #DriveDelay;
            $display("%0d rows passed, %0d rows failed", passCount, failCount);
            if (failCount == 0) begin
                $display("Test OK");
            end else begin
                $display("Test FAILED");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/execCore_golden.txt */
// Columns: mode (1 drive, 0 idle, F end), instruction, expected valid, expected error,
// expected result (compared only when valid is expected)
1 12007800 1 0 000003FF  // or r15, r16, r0 gives the return reset value
1 10A01000 1 0 00000000  // or r2, r5, r0
1 20017FFF 1 0 00007FFF  // addi r1, r0, 0x7fff
1 2002FFF6 1 0 FFFFFFF6  // addi r2, r0, -10 sign-extended
1 3C037FFF 1 0 7FFF0000  // lui r3, 0x7fff
1 3C048000 1 0 80000000  // lui r4, 0x8000
1 04632800 1 0 FFFE0000  // add r5, r3, r3 overflows
1 04223000 1 0 00007FF5  // add r6, r1, r2
1 08413800 1 0 FFFF7FF7  // sub r7, r2, r1
1 08814000 1 0 7FFF8001  // sub r8, r4, r1 wraps
1 0C434800 1 0 7FFF0000  // and r9, r2, r3
1 10245000 1 0 80007FFF  // or r10, r1, r4
1 14415800 1 0 FFFF8009  // xor r11, r2, r1
1 18416000 1 0 00000001  // slt r12, r2, r1 negative below positive
1 18226800 1 0 00000000  // slt r13, r1, r2
1 18806800 1 0 00000001  // slt r13, r4, r0
1 198C7000 1 0 00000000  // slt r14, r12, r12 equal
1 20200005 1 0 00008004  // addi r0, r1, 5 is not stored
1 10007000 1 0 00000000  // or r14, r0, r0
1 20140123 1 0 00000123  // addi r20, r0, 0x123 out of range
1 12807000 1 0 00000000  // or r14, r20, r0
1 20210001 1 0 00008000  // addi r1, r1, 1
1 04210800 1 0 00010000  // add r1, r1, r1 uses the previous result
1 08260800 1 0 0000800B  // sub r1, r1, r6
1 FC210800 0 1 00000000  // opcode 0x3f
1 1C210001 0 1 00000000  // opcode 0x07
1 10207000 1 0 0000800B  // or r14, r1, r0 unchanged
1 00000000 1 0 00000000  // nop
1 03FFFFFF 1 0 00000000  // nop with nonzero fields
0 04210800 0 0 00000000  // idle, add r1 not taken
0 00000000 0 0 00000000  // idle
1 10207000 1 0 0000800B  // or r14, r1, r0
1 11E07000 1 0 000003FF  // or r14, r15, r0
1 06108000 1 0 000007FE  // add r16, r16, r16
1 12007000 1 0 000007FE  // or r14, r16, r0
F 00000000 0 0 00000000  // end of table

/* src.f */
design/cpuPkg.sv
design/regBank.sv
design/instrDecoder.sv
design/aluUnit.sv
design/execCore.sv
tests/clockGen.sv
tests/execCore_props.sv
tests/execCoreTb.sv

/* run.sh */
#!/bin/sh
# Build the execCore testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module execCoreTb -f src.f \
    || { echo "Verilator build failed"; exit 1; }

simOut=$(./obj_dir/VexecCoreTb)
simStatus=$?
echo "$simOut"

[ "$simStatus" -eq 0 ] && echo "$simOut" | grep -qx "Test OK" && exit 0 || exit 1
